/* verilog/issue_isa_pkg.sv */
package issue_isa_pkg;

	// =========================================================================
	// Data path sizes
	// =========================================================================

	// Width of every operand and result in the core
	localparam int DATA_W = 16;

	// The tag rides along with an instruction and comes back out at commit
	localparam int TAG_W = 3;

	// Opcode encodings, top nibble of the instruction word
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_XOR  = 4'h3,
		OP_MUL  = 4'h4,
		OP_CEQ  = 4'h8,
		OP_CLT  = 4'h9,
		OP_SYNC = 4'hF
	} opcode_t;

	// Register pair form, two 12 bit operands
	typedef struct packed {
		logic [11:0] a;
		logic [11:0] b;
	} opnd_rr_t;

	// Immediate form, an 8 bit operand and a 16 bit immediate
	typedef struct packed {
		logic [7:0]  a;
		logic [15:0] imm;
	} opnd_ri_t;

	// The same 24 operand bits read either way, picked by the form bit
	typedef union packed {
		opnd_rr_t rr;
		opnd_ri_t ri;
	} operand_u;

	// Form bit set selects the immediate layout
	typedef struct packed {
		opcode_t          op;
		logic             form;
		logic [TAG_W-1:0] tag;
		operand_u         opnd;
	} insn_word_t;

	// Decoded instruction as held in a ROB entry
	typedef struct packed {
		logic              alu;
		logic              alu0;
		logic              fc;
		logic              sync;
		opcode_t           op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [TAG_W-1:0]  tag;
	} decbus_t;

endpackage

/* verilog/issue_rob_pkg.sv */
package issue_rob_pkg;

	// =========================================================================
	// ROB geometry
	// =========================================================================

	// Eight entries, so three index bits
	localparam int ROB_NDX_W = 3;

	// One extra bit over the index keeps head-relative ages unambiguous
	localparam int SN_W = ROB_NDX_W + 1;

	typedef logic [ROB_NDX_W-1:0] rob_ndx_t;
	typedef logic [SN_W-1:0] seqnum_t;
	typedef logic [(1 << ROB_NDX_W)-1:0] rob_bitmask_t;

	// One slot of the reorder buffer
	typedef struct packed {
		logic                           v;
		logic                           issued;
		logic                           done;
		seqnum_t                        sn;
		issue_isa_pkg::decbus_t         decbus;
		logic [issue_isa_pkg::DATA_W-1:0] res;
	} rob_entry_t;

	// Execution units, also the order in which a ready entry is offered to them
	typedef enum logic [1:0] {
		UNIT_ALU0 = 2'd0,
		UNIT_ALU1 = 2'd1,
		UNIT_FCU  = 2'd2
	} unit_id_t;

endpackage

/* verilog/fu_issue_if.sv */
`timescale 1ns/10ps

interface fu_issue_if;
	import issue_isa_pkg::*;
	import issue_rob_pkg::*;

	// Grant from the scheduler, valid for a single cycle
	logic              issue_v;
	rob_ndx_t          rndx;
	opcode_t           op;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;

	// Unit status and its one-cycle result strobe back into the ROB
	logic              idle;
	logic              wb_v;
	rob_ndx_t          wb_ndx;
	logic [DATA_W-1:0] wb_val;

	modport sched (output issue_v, rndx, op, a, b, input idle);
	modport unit (input issue_v, rndx, op, a, b, output idle, wb_v, wb_ndx, wb_val);

endinterface

/* verilog/insn_decode.sv */
`timescale 1ns/10ps

module insn_decode (
	input  logic                      dispatch_v_i,
	input  issue_isa_pkg::insn_word_t insn_i,
	output logic                      dec_v_o,
	output issue_isa_pkg::decbus_t    dec_o
);
	import issue_isa_pkg::*;

	// The decoded word lands in the ROB on the same edge that samples the strobe
	assign dec_v_o = dispatch_v_i;

	always_comb begin
		dec_o = '0;
		dec_o.op = insn_i.op;
		dec_o.tag = insn_i.tag;

		// Both operand layouts zero extend to the full data width
		if (insn_i.form) begin
			dec_o.a = DATA_W'(insn_i.opnd.ri.a);
			dec_o.b = insn_i.opnd.ri.imm;
		end else begin
			dec_o.a = DATA_W'(insn_i.opnd.rr.a);
			dec_o.b = DATA_W'(insn_i.opnd.rr.b);
		end

		// Unit class flags used by the scheduler
		case (insn_i.op)
			OP_MUL: begin
				// Only ALU0 carries the multiplier
				dec_o.alu = 1'b1;
				dec_o.alu0 = 1'b1;
			end
			OP_CEQ, OP_CLT: dec_o.fc = 1'b1;
			OP_SYNC: dec_o.sync = 1'b1;
			// Unknown opcodes go to an ALU and come back as zero, so they still retire
			default: dec_o.alu = 1'b1;
		endcase
	end

endmodule

/* verilog/rob_table.sv */
`timescale 1ns/10ps

module rob_table #(
	parameter int ROB_ENTRIES = 8
) (
	input  logic                                        clk_i,
	input  logic                                        rst_i,
	input  logic                                        dec_v_i,
	input  issue_isa_pkg::decbus_t                      dec_i,
	input  issue_rob_pkg::rob_bitmask_t                 issue_mask_i,
	fu_issue_if.unit                                    alu0_if,
	fu_issue_if.unit                                    alu1_if,
	fu_issue_if.unit                                    fcu_if,
	input  logic                                        retire_i,
	output issue_rob_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob_o,
	output issue_rob_pkg::rob_ndx_t                     head_o,
	output issue_rob_pkg::rob_bitmask_t                 could_issue_o,
	output logic                                        full_o
);
	import issue_rob_pkg::*;

	rob_ndx_t head_q;
	rob_ndx_t tail_q;
	seqnum_t  sn_q;
	logic [ROB_ENTRIES-1:0] valid_w;

	// Pointer step with wrap at the ROB depth
	function automatic rob_ndx_t bump(rob_ndx_t p);
		return (int'(p) == ROB_ENTRIES - 1) ? '0 : p + 1'b1;
	endfunction

	always_comb begin
		could_issue_o = '0;
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			valid_w[i] = rob_o[i].v;
			could_issue_o[i] = rob_o[i].v & ~rob_o[i].issued;
		end
	end

	assign full_o = &valid_w;
	assign head_o = head_q;

	// =========================================================================
	// Allocate, mark and retire
	// =========================================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				rob_o[i].v <= 1'b0;
				rob_o[i].issued <= 1'b0;
				rob_o[i].done <= 1'b0;
			end
			head_q <= '0;
			tail_q <= '0;
			sn_q <= '0;
		end else begin
			if (dec_v_i) begin
				// A SYNC needs no unit and is complete the moment it is allocated
				rob_o[tail_q].v <= 1'b1;
				rob_o[tail_q].issued <= dec_i.sync;
				rob_o[tail_q].done <= dec_i.sync;
				rob_o[tail_q].sn <= sn_q;
				rob_o[tail_q].decbus <= dec_i;
				rob_o[tail_q].res <= '0;
				tail_q <= bump(tail_q);
				sn_q <= sn_q + 1'b1;
			end
			for (int i = 0; i < ROB_ENTRIES; i++)
				if (issue_mask_i[i])
					rob_o[i].issued <= 1'b1;
			// Each unit writes its own slot, never the same one as another unit
			if (alu0_if.wb_v) begin
				rob_o[alu0_if.wb_ndx].done <= 1'b1;
				rob_o[alu0_if.wb_ndx].res <= alu0_if.wb_val;
			end
			if (alu1_if.wb_v) begin
				rob_o[alu1_if.wb_ndx].done <= 1'b1;
				rob_o[alu1_if.wb_ndx].res <= alu1_if.wb_val;
			end
			if (fcu_if.wb_v) begin
				rob_o[fcu_if.wb_ndx].done <= 1'b1;
				rob_o[fcu_if.wb_ndx].res <= fcu_if.wb_val;
			end
			if (retire_i) begin
				rob_o[head_q].v <= 1'b0;
				head_q <= bump(head_q);
			end
		end
	end

	// The source must honor full_o before it strobes
	a_no_dispatch_full: assert property (@(posedge clk_i) disable iff (rst_i)
		dec_v_i |-> !full_o);

	// A result may only land in a live entry that was granted some cycles before
	property p_wb_to_issued(v, ndx);
		@(posedge clk_i) disable iff (rst_i) v |-> rob_o[ndx].v && rob_o[ndx].issued;
	endproperty
	a_wb_alu0: assert property (p_wb_to_issued(alu0_if.wb_v, alu0_if.wb_ndx));
	a_wb_alu1: assert property (p_wb_to_issued(alu1_if.wb_v, alu1_if.wb_ndx));
	a_wb_fcu: assert property (p_wb_to_issued(fcu_if.wb_v, fcu_if.wb_ndx));

endmodule

/* verilog/issue_sched.sv */
`timescale 1ns/10ps

module issue_sched #(
	parameter int ROB_ENTRIES = 8,
	parameter int WINDOW_SIZE = 8
) (
	input  logic                                        clk_i,
	input  issue_rob_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input  issue_rob_pkg::rob_ndx_t                     head_i,
	input  issue_rob_pkg::rob_bitmask_t                 could_issue_i,
	fu_issue_if.sched                                   alu0_if,
	fu_issue_if.sched                                   alu1_if,
	fu_issue_if.sched                                   fcu_if,
	output issue_rob_pkg::rob_bitmask_t                 issue_mask_o
);
	import issue_isa_pkg::*;
	import issue_rob_pkg::*;

	logic [2:0] idle_w;
	logic [2:0] taken;
	rob_ndx_t   g_ndx [3];
	rob_ndx_t   ndx;
	logic       sync_seen;

	// Which units may execute a given decoded instruction
	function automatic logic fits(unit_id_t u, decbus_t d);
		case (u)
			UNIT_ALU0: return d.alu;
			UNIT_ALU1: return d.alu & ~d.alu0;
			UNIT_FCU: return d.fc;
			default: return 1'b0;
		endcase
	endfunction

	assign idle_w[UNIT_ALU0] = alu0_if.idle;
	assign idle_w[UNIT_ALU1] = alu1_if.idle;
	assign idle_w[UNIT_FCU] = fcu_if.idle;

	// =========================================================================
	// Oldest first selection
	// =========================================================================

	// Slots are visited from the head, which is program order.
	// Once a live SYNC has been passed nothing further may go.
	always_comb begin
		taken = '0;
		issue_mask_o = '0;
		sync_seen = 1'b0;
		ndx = '0;
		for (int u = 0; u < 3; u++)
			g_ndx[u] = '0;
		for (int hd = 0; hd < WINDOW_SIZE; hd++) begin
			ndx = rob_ndx_t'((int'(head_i) + hd) % ROB_ENTRIES);
			if (!sync_seen && could_issue_i[ndx]) begin
				for (int u = 0; u < 3; u++) begin
					// An entry takes at most one unit per cycle
					if (!taken[u] && idle_w[u] && !issue_mask_o[ndx] &&
							fits(unit_id_t'(u), rob_i[ndx].decbus)) begin
						taken[u] = 1'b1;
						g_ndx[u] = ndx;
						issue_mask_o[ndx] = 1'b1;
					end
				end
			end
			if (rob_i[ndx].v && rob_i[ndx].decbus.sync)
				sync_seen = 1'b1;
		end
	end

	// Drive each unit with its granted entry's operands
	assign alu0_if.issue_v = taken[UNIT_ALU0];
	assign alu0_if.rndx = g_ndx[UNIT_ALU0];
	assign alu0_if.op = rob_i[g_ndx[UNIT_ALU0]].decbus.op;
	assign alu0_if.a = rob_i[g_ndx[UNIT_ALU0]].decbus.a;
	assign alu0_if.b = rob_i[g_ndx[UNIT_ALU0]].decbus.b;

	assign alu1_if.issue_v = taken[UNIT_ALU1];
	assign alu1_if.rndx = g_ndx[UNIT_ALU1];
	assign alu1_if.op = rob_i[g_ndx[UNIT_ALU1]].decbus.op;
	assign alu1_if.a = rob_i[g_ndx[UNIT_ALU1]].decbus.a;
	assign alu1_if.b = rob_i[g_ndx[UNIT_ALU1]].decbus.b;

	assign fcu_if.issue_v = taken[UNIT_FCU];
	assign fcu_if.rndx = g_ndx[UNIT_FCU];
	assign fcu_if.op = rob_i[g_ndx[UNIT_FCU]].decbus.op;
	assign fcu_if.a = rob_i[g_ndx[UNIT_FCU]].decbus.a;
	assign fcu_if.b = rob_i[g_ndx[UNIT_FCU]].decbus.b;

	// Age of an entry counted from the head's sequence number
	function automatic seqnum_t age(seqnum_t sn);
		return sn - rob_i[head_i].sn;
	endfunction

	// Entries that have a live SYNC older than themselves anywhere in the ROB
	function automatic rob_bitmask_t sync_shadow();
		rob_bitmask_t m;
		m = '0;
		for (int i = 0; i < ROB_ENTRIES; i++)
			for (int j = 0; j < ROB_ENTRIES; j++)
				if (rob_i[j].v && rob_i[j].decbus.sync && age(rob_i[j].sn) < age(rob_i[i].sn))
					m[i] = 1'b1;
		return m;
	endfunction

	a_sync_order: assert property (@(posedge clk_i) (issue_mask_o & sync_shadow()) == '0);

endmodule

/* verilog/alu_exec.sv */
`timescale 1ns/10ps

module alu_exec #(
	parameter int MUL_LATENCY = 4,
	parameter bit HAS_MUL = 1'b1
) (
	input  logic     clk_i,
	input  logic     rst_i,
	fu_issue_if.unit fu
);
	import issue_isa_pkg::*;
	import issue_rob_pkg::*;

	localparam int CNT_W = $clog2(MUL_LATENCY + 1);

	logic [CNT_W-1:0]    cnt_q;
	logic                wb_v_q;
	rob_ndx_t            ndx_q;
	logic [DATA_W-1:0]   res_q;
	logic [DATA_W-1:0]   res_w;
	logic [2*DATA_W-1:0] prod_w;
	logic                long_w;

	// Full product, only the low half is kept
	assign prod_w = fu.a * fu.b;

	// A multiply is the only operation that holds the unit for more than one cycle
	assign long_w = HAS_MUL && (fu.op == OP_MUL) && (MUL_LATENCY > 1);

	always_comb begin
		case (fu.op)
			OP_ADD: res_w = fu.a + fu.b;
			OP_SUB: res_w = fu.a - fu.b;
			OP_AND: res_w = fu.a & fu.b;
			OP_XOR: res_w = fu.a ^ fu.b;
			OP_MUL: res_w = HAS_MUL ? prod_w[DATA_W-1:0] : '0;
			default: res_w = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_q <= '0;
			wb_v_q <= 1'b0;
		end else begin
			wb_v_q <= 1'b0;
			if (cnt_q != '0) begin
				// Count down the remaining multiply cycles, result goes out on the last
				cnt_q <= cnt_q - 1'b1;
				wb_v_q <= (cnt_q == CNT_W'(1));
			end else if (fu.issue_v) begin
				if (long_w)
					cnt_q <= CNT_W'(MUL_LATENCY - 1);
				else
					wb_v_q <= 1'b1;
			end
		end
	end

	// Index and result are captured with the grant
	always_ff @(posedge clk_i)
		if (fu.issue_v && cnt_q == '0) begin
			ndx_q <= fu.rndx;
			res_q <= res_w;
		end

	assign fu.idle = (cnt_q == '0);
	assign fu.wb_v = wb_v_q;
	assign fu.wb_ndx = ndx_q;
	assign fu.wb_val = res_q;

	// The scheduler must see the unit busy for the whole multiply
	a_no_grant_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		fu.issue_v |-> fu.idle);

endmodule

/* verilog/fcu_exec.sv */
`timescale 1ns/10ps

module fcu_exec (
	input  logic     clk_i,
	input  logic     rst_i,
	fu_issue_if.unit fu
);
	import issue_isa_pkg::*;
	import issue_rob_pkg::*;

	logic              wb_v_q;
	rob_ndx_t          ndx_q;
	logic              hit_q;
	logic              hit_w;

	// Compare outcome, both compares are unsigned
	always_comb begin
		case (fu.op)
			OP_CEQ: hit_w = (fu.a == fu.b);
			OP_CLT: hit_w = (fu.a < fu.b);
			default: hit_w = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i)
		if (rst_i)
			wb_v_q <= 1'b0;
		else
			wb_v_q <= fu.issue_v;

	always_ff @(posedge clk_i)
		if (fu.issue_v) begin
			ndx_q <= fu.rndx;
			hit_q <= hit_w;
		end

	// Single cycle unit, it can take a new compare every clock
	assign fu.idle = 1'b1;
	assign fu.wb_v = wb_v_q;
	assign fu.wb_ndx = ndx_q;
	assign fu.wb_val = DATA_W'(hit_q);

endmodule

/* verilog/rob_commit.sv */
`timescale 1ns/10ps

module rob_commit #(
	parameter int ROB_ENTRIES = 8
) (
	input  logic                                        clk_i,
	input  logic                                        rst_i,
	input  issue_rob_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input  issue_rob_pkg::rob_ndx_t                     head_i,
	output logic                                        retire_o,
	output logic                                        commit_v_o,
	output logic [issue_isa_pkg::TAG_W-1:0]             commit_tag_o,
	output logic [issue_isa_pkg::DATA_W-1:0]            commit_val_o
);
	import issue_rob_pkg::*;

	rob_entry_t head_w;

	assign head_w = rob_i[head_i];

	// Head leaves the ROB as soon as it is complete, one entry per clock
	assign retire_o = head_w.v & head_w.done;

	always_ff @(posedge clk_i)
		if (rst_i)
			commit_v_o <= 1'b0;
		else
			commit_v_o <= retire_o;

	// A SYNC produces no value of its own
	always_ff @(posedge clk_i)
		if (retire_o) begin
			commit_tag_o <= head_w.decbus.tag;
			commit_val_o <= head_w.decbus.sync ? '0 : head_w.res;
		end

endmodule

/* verilog/issue_core.sv */
`timescale 1ns/10ps

module issue_core #(
	parameter int ROB_ENTRIES = 8,
	parameter int WINDOW_SIZE = 8,
	parameter int MUL_LATENCY = 4
) (
	input  logic                             clk_i,
	input  logic                             rst_i,
	input  logic                             dispatch_v_i,
	input  issue_isa_pkg::insn_word_t        insn_i,
	output logic                             full_o,
	output logic                             commit_v_o,
	output logic [issue_isa_pkg::TAG_W-1:0]  commit_tag_o,
	output logic [issue_isa_pkg::DATA_W-1:0] commit_val_o
);
	import issue_isa_pkg::*;
	import issue_rob_pkg::*;

	logic                         dec_v;
	decbus_t                      dec;
	rob_entry_t [ROB_ENTRIES-1:0] rob;
	rob_ndx_t                     head;
	rob_bitmask_t                 could_issue;
	rob_bitmask_t                 issue_mask;
	logic                         retire;

	// One grant and writeback channel per execution unit
	fu_issue_if alu0_bus ();
	fu_issue_if alu1_bus ();
	fu_issue_if fcu_bus ();

	insn_decode u_decode (.dispatch_v_i, .insn_i, .dec_v_o(dec_v), .dec_o(dec));

	rob_table #(.ROB_ENTRIES(ROB_ENTRIES)) u_rob (
		.clk_i, .rst_i, .dec_v_i(dec_v), .dec_i(dec), .issue_mask_i(issue_mask),
		.alu0_if(alu0_bus), .alu1_if(alu1_bus), .fcu_if(fcu_bus), .retire_i(retire),
		.rob_o(rob), .head_o(head), .could_issue_o(could_issue), .full_o
	);

	issue_sched #(.ROB_ENTRIES(ROB_ENTRIES), .WINDOW_SIZE(WINDOW_SIZE)) u_sched (
		.clk_i, .rob_i(rob), .head_i(head), .could_issue_i(could_issue),
		.alu0_if(alu0_bus), .alu1_if(alu1_bus), .fcu_if(fcu_bus), .issue_mask_o(issue_mask)
	);

	// ALU0 has the multiplier, ALU1 does not
	alu_exec #(.MUL_LATENCY(MUL_LATENCY), .HAS_MUL(1'b1)) u_alu0 (
		.clk_i, .rst_i, .fu(alu0_bus));
	alu_exec #(.MUL_LATENCY(MUL_LATENCY), .HAS_MUL(1'b0)) u_alu1 (
		.clk_i, .rst_i, .fu(alu1_bus));

	fcu_exec u_fcu (.clk_i, .rst_i, .fu(fcu_bus));

	rob_commit #(.ROB_ENTRIES(ROB_ENTRIES)) u_commit (
		.clk_i, .rst_i, .rob_i(rob), .head_i(head), .retire_o(retire),
		.commit_v_o, .commit_tag_o, .commit_val_o
	);

endmodule

/* verification/issue_core_tb.sv */
`timescale 1ns/10ps

module issue_core_tb;
	import issue_isa_pkg::*;

	// Room in the test table and the watchdog budget for each test line
	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 40;
	localparam int ROB_DEPTH = 8;
	localparam string TESTS_FILE = "verification/issue_core_tests.txt";

	logic              clk;
	logic              rst;
	logic              dispatch_v;
	insn_word_t        insn;
	logic              full;
	logic              commit_v;
	logic [TAG_W-1:0]  commit_tag;
	logic [DATA_W-1:0] commit_val;

	// Instruction words and their expected results in file order
	logic [31:0]       test_word [MAX_TESTS];
	logic [DATA_W-1:0] test_exp [MAX_TESTS];
	int                n_tests;

	// Expected commit stream that is pushed at dispatch and popped at each commit
	logic [TAG_W-1:0]  exp_tag_q [$];
	logic [DATA_W-1:0] exp_val_q [$];

	int errors;
	int commits;
	bit saw_full;

	// =========================================================================
	// DUT and clock
	// =========================================================================

	issue_core #(
		.ROB_ENTRIES(ROB_DEPTH),
		.WINDOW_SIZE(8),
		.MUL_LATENCY(4)
	) dut0 (
		.clk_i(clk),
		.rst_i(rst),
		.dispatch_v_i(dispatch_v),
		.insn_i(insn),
		.full_o(full),
		.commit_v_o(commit_v),
		.commit_tag_o(commit_tag),
		.commit_val_o(commit_val)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// =========================================================================
	// Test table and dispatch
	// =========================================================================

	// Each data line holds a hex word and its hex result
	// Lines that start with a hash are notes
	task automatic load_tests();
		int                fd;
		int                cnt;
		string             line;
		logic [31:0]       w;
		logic [DATA_W-1:0] e;
		n_tests = 0;
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0) begin
			$display("Could not open %s for reading", TESTS_FILE);
			errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.substr(0, 0) == "#")
				continue;
			cnt = $sscanf(line, "%h %h", w, e);
			if (cnt == 2 && n_tests < MAX_TESTS) begin
				test_word[n_tests] = w;
				test_exp[n_tests] = e;
				n_tests++;
			end else if (cnt == 2) begin
				$display("The tests file has more than %0d lines", MAX_TESTS);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// An entry leaves the ROB on the edge that raises commit_v_o
	// The queue drops it only at the following falling edge
	task automatic check_full_flag();
		int   held;
		logic exp_full;
		held = exp_tag_q.size() - ((commit_v === 1'b1) ? 1 : 0);
		exp_full = (held == ROB_DEPTH);
		if (full !== exp_full) begin
			$display("error full_o: got %h, expected %h with %0d entries held",
				full, exp_full, held);
			errors++;
		end
	endtask

	// Inputs change 1 ns after the rising edge and the strobe waits out a full ROB
	task automatic dispatch_insn(input logic [31:0] w, input logic [DATA_W-1:0] e);
		@(posedge clk);
		#1;
		dispatch_v = 1'b0;
		check_full_flag();
		while (full) begin
			saw_full = 1'b1;
			@(posedge clk);
			#1;
			check_full_flag();
		end
		insn = w;
		dispatch_v = 1'b1;
		// The tag rides in bits 26 to 24 of the word
		exp_tag_q.push_back(w[26:24]);
		exp_val_q.push_back(e);
	endtask

	initial begin
		errors = 0;
		commits = 0;
		saw_full = 1'b0;
		rst = 1'b1;
		dispatch_v = 1'b0;
		insn = '0;
		load_tests();

		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		// Nothing may retire from an empty ROB
		repeat (4) begin
			@(posedge clk);
			#1;
			if (commit_v !== 1'b0) begin
				$display("error commit_v_o: got %h, expected 0 before any dispatch", commit_v);
				errors++;
			end
		end

		// One back to back burst that is long enough to fill the ROB behind the multiplies
		for (int i = 0; i < n_tests; i++)
			dispatch_insn(test_word[i], test_exp[i]);
		@(posedge clk);
		#1;
		dispatch_v = 1'b0;

		wait (commits >= n_tests);
		// Some quiet cycles so that a stray extra commit still shows up
		repeat (8) @(posedge clk);

		if (n_tests == 0) begin
			$display("No test lines were read from the tests file");
			errors++;
		end
		if (commits != n_tests) begin
			$display("Saw %0d commits for %0d dispatched instructions", commits, n_tests);
			errors++;
		end
		if (!saw_full) begin
			$display("The full flag never rose during the dispatch burst");
			errors++;
		end
		$display("Errors: %0d, commits: %0d of %0d", errors, commits, n_tests);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// =========================================================================
	// Commit checking
	// =========================================================================

	// Outputs change on the rising edge, so they are read on the falling one
	always @(negedge clk) begin : commit_check
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] val;
		if (!rst && commit_v === 1'b1) begin
			commits++;
			if (exp_tag_q.size() == 0) begin
				$display("A commit with tag %h came out with no instruction outstanding",
					commit_tag);
				errors++;
			end else begin
				tag = exp_tag_q.pop_front();
				val = exp_val_q.pop_front();
				if (commit_tag !== tag) begin
					$display("error commit_tag_o: got %h, expected %h at commit %0d",
						commit_tag, tag, commits);
					errors++;
				end
				if (commit_val !== val) begin
					$display("error commit_val_o: got %h, expected %h at commit %0d",
						commit_val, val, commits);
					errors++;
				end
			end
		end
	end

	// Budget scales with the number of test lines read
	initial begin : watchdog
		@(negedge rst);
		repeat ((n_tests + 1) * CYCLES_PER_TEST) @(posedge clk);
		$display("The run timed out with %0d of %0d commits seen", commits, n_tests);
		$display("Errors: %0d, commits: %0d of %0d", errors + 1, commits, n_tests);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* issue_core.f */
verilog/issue_isa_pkg.sv
verilog/issue_rob_pkg.sv
verilog/fu_issue_if.sv
verilog/insn_decode.sv
verilog/rob_table.sv
verilog/issue_sched.sv
verilog/alu_exec.sv
verilog/fcu_exec.sv
verilog/rob_commit.sv
verilog/issue_core.sv
verification/issue_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the issue_core testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module issue_core_tb -f issue_core.f -Mdir obj_dir -o issue_core_sim &&
	./obj_dir/issue_core_sim | tee /dev/stderr |
	grep -x "Simulation completed successfully" > /dev/null &&
	echo "PASS" ||
	{ echo "FAIL"; exit 1; }

/* verification/issue_core_tests.txt */
# Columns: instruction word (hex), expected committed result (hex)
# Word: opcode [31:28], form [27], tag [26:24], operands [23:0]
01123456 0579
12100200 FF00
2BF03CFF 00F0
3CAAFFFF FF55
0DFFFF80 007F
461230FF 21DD
27FFF0F0 00F0
80055055 0001
91200100 0000
9A108000 0001
8B121234 0000
4CFFFFFF FF01
45FFFFFF E001
4E120100 1200
F7ABCDEF 0000
18050007 FFFE
31ABC123 0B9F
02FFFFFF 1FFE
937FF800 0001
44002003 0006
2D3C00F0 0030
F6000000 0000
0F01FFFF 0000
